// File: verilog/axi_port_defs.svh
`ifndef AXI_PORT_DEFS_SVH
`define AXI_PORT_DEFS_SVH

// AXI field widths
`define AXI_ID_W      4
`define AXI_ADDR_W    32
`define AXI_DATA_W    32
`define AXI_STRB_W    (`AXI_DATA_W / 8)
`define AXI_LEN_W     8
`define AXI_SIZE_W    3
`define AXI_BURST_W   2
`define AXI_RESP_W    2

// Operation type codes for MEM_OP_TYPE
`define MEM_OP_READ   1
`define MEM_OP_WRITE  2
`define MEM_OP_RW     3

// Room for more bursts than the downstream limit of 32
`define OUTSTANDING_W 6

`endif

// File: verilog/axi_port_pkg.sv
`default_nettype none

`include "axi_port_defs.svh"

package axi_port_pkg;

	// **************************************************************************
	// AXI fields
	// **************************************************************************
	typedef logic [`AXI_ID_W-1:0]    axi_id_t;
	typedef logic [`AXI_ADDR_W-1:0]  axi_addr_t;
	typedef logic [`AXI_DATA_W-1:0]  axi_data_t;
	typedef logic [`AXI_STRB_W-1:0]  axi_strb_t;
	// Beats minus one
	typedef logic [`AXI_LEN_W-1:0]   axi_len_t;
	// log2 of bytes per beat
	typedef logic [`AXI_SIZE_W-1:0]  axi_size_t;
	typedef logic [`AXI_BURST_W-1:0] axi_burst_t;
	typedef logic [`AXI_RESP_W-1:0]  axi_resp_t;

	// Bursts in flight
	typedef logic [`OUTSTANDING_W-1:0] outstanding_t;

	// One-entry address buffer
	typedef enum logic {
		STAGE_EMPTY = 1'b0,
		STAGE_FULL  = 1'b1
	} addr_stage_state_t;

endpackage

`default_nettype wire

// File: verilog/axi_addr_stage.sv
`default_nettype none

module axi_addr_stage (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    clear,
	input  wire logic                    enable,

	// Upstream address request
	input  wire axi_port_pkg::axi_id_t    in_id,
	input  wire axi_port_pkg::axi_addr_t  in_addr,
	input  wire axi_port_pkg::axi_len_t   in_len,
	input  wire axi_port_pkg::axi_size_t  in_size,
	input  wire axi_port_pkg::axi_burst_t in_burst,
	input  wire logic                    in_valid,
	output logic                         in_ready,

	// Downstream address request
	output axi_port_pkg::axi_id_t         out_id,
	output axi_port_pkg::axi_addr_t       out_addr,
	output axi_port_pkg::axi_len_t        out_len,
	output axi_port_pkg::axi_size_t       out_size,
	output axi_port_pkg::axi_burst_t      out_burst,
	output logic                         out_valid,
	input  wire logic                    out_ready,

	output logic                         empty
);

	import axi_port_pkg::*;

	addr_stage_state_t state;
	addr_stage_state_t state_next;

	logic in_fire;
	logic out_fire;

	// **************************************************************************
	// Handshakes
	// **************************************************************************

	// Accept while enabled and not flushing, if the slot is free or draining
	assign in_ready = enable & ~clear & ((state == STAGE_EMPTY) | out_ready);
	assign in_fire = in_valid & in_ready;

	assign out_valid = (state == STAGE_FULL);
	assign out_fire = out_valid & out_ready;

	assign empty = (state == STAGE_EMPTY);

	// **************************************************************************
	// State machine
	// **************************************************************************

	always_comb begin
		state_next = state;
		if (clear) begin
			state_next = STAGE_EMPTY;
		end else begin
			case (state)
				STAGE_EMPTY: begin
					if (in_fire)
						state_next = STAGE_FULL;
				end
				STAGE_FULL: begin
					// Drain and refill on the same edge keeps it full
					if (out_fire && !in_fire)
						state_next = STAGE_EMPTY;
				end
				default: state_next = STAGE_EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= STAGE_EMPTY;
		else
			state <= state_next;
	end

	// Payload captured on acceptance
	always_ff @(posedge clk) begin
		if (in_fire) begin
			out_id    <= in_id;
			out_addr  <= in_addr;
			out_len   <= in_len;
			out_size  <= in_size;
			out_burst <= in_burst;
		end
	end

endmodule

`default_nettype wire

// File: verilog/axi_outstanding_tracker.sv
`default_nettype none

module axi_outstanding_tracker (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic clear,

	// Manager-side transfer strobes
	input  wire logic ar_fire,
	input  wire logic r_last_fire,
	input  wire logic aw_fire,
	input  wire logic b_fire,

	// Address stage occupancy
	input  wire logic ar_empty,
	input  wire logic aw_empty,

	output logic      idle
);

	import axi_port_pkg::*;

	outstanding_t read_cnt;
	outstanding_t write_cnt;

	logic idle_next;

	// **************************************************************************
	// Burst counters
	// **************************************************************************

	// Read bursts between AR and the last R beat
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			read_cnt <= '0;
		end else if (clear) begin
			read_cnt <= '0;
		end else begin
			case ({ar_fire, r_last_fire})
				2'b10:   read_cnt <= read_cnt + 1'b1;
				2'b01:   read_cnt <= read_cnt - 1'b1;
				default: read_cnt <= read_cnt;
			endcase
		end
	end

	// Write bursts between AW and B
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			write_cnt <= '0;
		end else if (clear) begin
			write_cnt <= '0;
		end else begin
			case ({aw_fire, b_fire})
				2'b10:   write_cnt <= write_cnt + 1'b1;
				2'b01:   write_cnt <= write_cnt - 1'b1;
				default: write_cnt <= write_cnt;
			endcase
		end
	end

	// Safe to disable once nothing is buffered or in flight
	assign idle_next = (read_cnt == '0) & (write_cnt == '0) & ar_empty & aw_empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			idle <= 1'b0;
		else
			idle <= idle_next;
	end

endmodule

`default_nettype wire

// File: verilog/axi_access_port.sv
`default_nettype none

`include "axi_port_defs.svh"

module axi_access_port #(
	parameter int MEM_OP_TYPE = `MEM_OP_RW
) (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    clear,
	input  wire logic                    enable,
	output logic                         idle,

	// Subordinate side AR
	input  wire axi_port_pkg::axi_id_t    s_arid,
	input  wire axi_port_pkg::axi_addr_t  s_araddr,
	input  wire axi_port_pkg::axi_len_t   s_arlen,
	input  wire axi_port_pkg::axi_size_t  s_arsize,
	input  wire axi_port_pkg::axi_burst_t s_arburst,
	input  wire logic                    s_arvalid,
	output logic                         s_arready,

	// Subordinate side AW
	input  wire axi_port_pkg::axi_id_t    s_awid,
	input  wire axi_port_pkg::axi_addr_t  s_awaddr,
	input  wire axi_port_pkg::axi_len_t   s_awlen,
	input  wire axi_port_pkg::axi_size_t  s_awsize,
	input  wire axi_port_pkg::axi_burst_t s_awburst,
	input  wire logic                    s_awvalid,
	output logic                         s_awready,

	// Subordinate side W
	input  wire axi_port_pkg::axi_id_t    s_wid,
	input  wire axi_port_pkg::axi_data_t  s_wdata,
	input  wire axi_port_pkg::axi_strb_t  s_wstrb,
	input  wire logic                    s_wlast,
	input  wire logic                    s_wvalid,
	output logic                         s_wready,

	// Subordinate side R
	output axi_port_pkg::axi_id_t         s_rid,
	output axi_port_pkg::axi_data_t       s_rdata,
	output axi_port_pkg::axi_resp_t       s_rresp,
	output logic                         s_rlast,
	output logic                         s_rvalid,
	input  wire logic                    s_rready,

	// Subordinate side B
	output axi_port_pkg::axi_id_t         s_bid,
	output axi_port_pkg::axi_resp_t       s_bresp,
	output logic                         s_bvalid,
	input  wire logic                    s_bready,

	// Manager side AR
	output axi_port_pkg::axi_id_t         m_arid,
	output axi_port_pkg::axi_addr_t       m_araddr,
	output axi_port_pkg::axi_len_t        m_arlen,
	output axi_port_pkg::axi_size_t       m_arsize,
	output axi_port_pkg::axi_burst_t      m_arburst,
	output logic                         m_arvalid,
	input  wire logic                    m_arready,

	// Manager side AW
	output axi_port_pkg::axi_id_t         m_awid,
	output axi_port_pkg::axi_addr_t       m_awaddr,
	output axi_port_pkg::axi_len_t        m_awlen,
	output axi_port_pkg::axi_size_t       m_awsize,
	output axi_port_pkg::axi_burst_t      m_awburst,
	output logic                         m_awvalid,
	input  wire logic                    m_awready,

	// Manager side W
	output axi_port_pkg::axi_id_t         m_wid,
	output axi_port_pkg::axi_data_t       m_wdata,
	output axi_port_pkg::axi_strb_t       m_wstrb,
	output logic                         m_wlast,
	output logic                         m_wvalid,
	input  wire logic                    m_wready,

	// Manager side R
	input  wire axi_port_pkg::axi_id_t    m_rid,
	input  wire axi_port_pkg::axi_data_t  m_rdata,
	input  wire axi_port_pkg::axi_resp_t  m_rresp,
	input  wire logic                    m_rlast,
	input  wire logic                    m_rvalid,
	output logic                         m_rready,

	// Manager side B
	input  wire axi_port_pkg::axi_id_t    m_bid,
	input  wire axi_port_pkg::axi_resp_t  m_bresp,
	input  wire logic                    m_bvalid,
	output logic                         m_bready
);

	// An unsupported direction never raises its address ready
	localparam bit READ_SUPPORTED  = (MEM_OP_TYPE == `MEM_OP_READ) ||
	                                 (MEM_OP_TYPE == `MEM_OP_RW);
	localparam bit WRITE_SUPPORTED = (MEM_OP_TYPE == `MEM_OP_WRITE) ||
	                                 (MEM_OP_TYPE == `MEM_OP_RW);

	logic ar_enable;
	logic aw_enable;
	logic ar_empty;
	logic aw_empty;

	logic ar_fire;
	logic aw_fire;
	logic r_last_fire;
	logic b_fire;

	assign ar_enable = enable & READ_SUPPORTED;
	assign aw_enable = enable & WRITE_SUPPORTED;

	// **************************************************************************
	// Address stages
	// **************************************************************************

	axi_addr_stage ar_stage_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (clear),
		.enable    (ar_enable),
		.in_id     (s_arid),
		.in_addr   (s_araddr),
		.in_len    (s_arlen),
		.in_size   (s_arsize),
		.in_burst  (s_arburst),
		.in_valid  (s_arvalid),
		.in_ready  (s_arready),
		.out_id    (m_arid),
		.out_addr  (m_araddr),
		.out_len   (m_arlen),
		.out_size  (m_arsize),
		.out_burst (m_arburst),
		.out_valid (m_arvalid),
		.out_ready (m_arready),
		.empty     (ar_empty)
	);

	axi_addr_stage aw_stage_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (clear),
		.enable    (aw_enable),
		.in_id     (s_awid),
		.in_addr   (s_awaddr),
		.in_len    (s_awlen),
		.in_size   (s_awsize),
		.in_burst  (s_awburst),
		.in_valid  (s_awvalid),
		.in_ready  (s_awready),
		.out_id    (m_awid),
		.out_addr  (m_awaddr),
		.out_len   (m_awlen),
		.out_size  (m_awsize),
		.out_burst (m_awburst),
		.out_valid (m_awvalid),
		.out_ready (m_awready),
		.empty     (aw_empty)
	);

	// **************************************************************************
	// Data and response pass-through
	// **************************************************************************

	assign m_wid    = s_wid;
	assign m_wdata  = s_wdata;
	assign m_wstrb  = s_wstrb;
	assign m_wlast  = s_wlast;
	assign m_wvalid = s_wvalid;
	assign s_wready = m_wready;

	assign s_rid    = m_rid;
	assign s_rdata  = m_rdata;
	assign s_rresp  = m_rresp;
	assign s_rlast  = m_rlast;
	assign s_rvalid = m_rvalid;
	assign m_rready = s_rready;

	assign s_bid    = m_bid;
	assign s_bresp  = m_bresp;
	assign s_bvalid = m_bvalid;
	assign m_bready = s_bready;

	// **************************************************************************
	// Outstanding tracking
	// **************************************************************************

	// Transfers as seen on the manager side
	assign ar_fire     = m_arvalid & m_arready;
	assign aw_fire     = m_awvalid & m_awready;
	assign r_last_fire = m_rvalid & m_rready & m_rlast;
	assign b_fire      = m_bvalid & m_bready;

	axi_outstanding_tracker tracker_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.clear       (clear),
		.ar_fire     (ar_fire),
		.r_last_fire (r_last_fire),
		.aw_fire     (aw_fire),
		.b_fire      (b_fire),
		.ar_empty    (ar_empty),
		.aw_empty    (aw_empty),
		.idle        (idle)
	);

endmodule

`default_nettype wire

// File: verif/axi_access_port_tests.svh
`ifndef AXI_ACCESS_PORT_TESTS_SVH
`define AXI_ACCESS_PORT_TESTS_SVH

// Called on a falling edge, returns on the falling edge after acceptance
task automatic send_addr(input bit is_write, input axi_addr_t addr);
	int n;
	logic ready;
	n = 0;
	if (is_write) begin
		s_awaddr = addr;
		s_awvalid = 1'b1;
	end else begin
		s_araddr = addr;
		s_arvalid = 1'b1;
	end
	do begin
		@(posedge clk);
		n++;
		ready = is_write ? s_awready : s_arready;
	end while (!ready && n < HANDSHAKE_LIMIT);
	if (!ready) begin
		$display("%s: address request was never accepted", test_name);
		test_errs++;
	end
	@(negedge clk);
	s_awvalid = 1'b0;
	s_arvalid = 1'b0;
endtask

task automatic write_burst(input burst_t data);
	for (int i = 0; i < 4; i++) begin
		s_wdata = data[i];
		s_wlast = (i == 3);
		s_wvalid = 1'b1;
		@(posedge clk);
		check(1, s_wready);
		check(1, m_wvalid);
		check(data[i], m_wdata);
		check(i == 3, m_wlast);
		check(s_wid, m_wid);
		check(s_wstrb, m_wstrb);
		@(negedge clk);
	end
	s_wvalid = 1'b0;
	s_wlast = 1'b0;
endtask

task automatic wait_bresp(input bit idle_low);
	int n;
	n = 0;
	do begin
		@(posedge clk);
		n++;
	end while (!(s_bvalid && s_bready) && n < HANDSHAKE_LIMIT);
	if (s_bvalid && s_bready) begin
		check(0, s_bresp);
		check(s_awid, s_bid);
		if (idle_low)
			check(0, idle);
	end else begin
		$display("%s: no write response arrived", test_name);
		test_errs++;
	end
	@(negedge clk);
endtask

task automatic read_burst(input burst_t expected, input bit idle_low);
	int beat;
	int n;
	beat = 0;
	n = 0;
	while (beat < 4 && n < HANDSHAKE_LIMIT) begin
		@(posedge clk);
		n++;
		if (s_rvalid && s_rready) begin
			check(expected[beat], s_rdata);
			check(beat == 3, s_rlast);
			check(0, s_rresp);
			check(s_arid, s_rid);
			if (idle_low)
				check(0, idle);
			beat++;
		end
	end
	if (beat < 4) begin
		$display("%s: read burst stopped after %0d of 4 beats", test_name, beat);
		test_errs++;
	end
	@(negedge clk);
endtask

task automatic expect_idle_within(input int cycles);
	int n;
	n = 1;
	while (!idle && n < cycles) begin
		@(negedge clk);
		n++;
	end
	if (!idle) begin
		$display("%s: idle did not rise within %0d cycles", test_name, cycles);
		test_errs++;
	end
endtask

// **************************************************************************
// Directed tests
// **************************************************************************

task automatic idle_tracking();
	axi_addr_t addr;
	burst_t data;
	begin_test("idle");
	addr = random_addr();
	check(1, idle);
	send_addr(1'b0, addr);
	read_burst(stored_burst(addr), 1'b1);
	expect_idle_within(2);
	for (int i = 0; i < 4; i++)
		data[i] = next_random();
	send_addr(1'b1, addr);
	write_burst(data);
	wait_bresp(1'b1);
	expect_idle_within(2);
	end_test();
endtask

task automatic write_then_read();
	axi_addr_t addr;
	burst_t data;
	begin_test("write_read");
	addr = random_addr();
	for (int i = 0; i < 4; i++)
		data[i] = next_random();
	send_addr(1'b1, addr);
	check(1, m_awvalid);
	check(addr, m_awaddr);
	check(s_awid, m_awid);
	check(s_awlen, m_awlen);
	check(s_awsize, m_awsize);
	check(s_awburst, m_awburst);
	write_burst(data);
	wait_bresp(1'b0);
	send_addr(1'b0, addr);
	// The request reaches the manager side one cycle after the AR transfer
	check(1, m_arvalid);
	check(addr, m_araddr);
	check(s_arid, m_arid);
	check(s_arlen, m_arlen);
	check(s_arsize, m_arsize);
	check(s_arburst, m_arburst);
	read_burst(data, 1'b0);
	end_test();
endtask

task automatic disable_gating();
	axi_addr_t addr;
	begin_test("disable");
	addr = random_addr();
	enable = 1'b0;
	s_araddr = addr;
	s_arvalid = 1'b1;
	repeat (20) begin
		@(posedge clk);
		check(0, s_arready);
		check(0, s_awready);
		check(0, m_arvalid);
	end
	@(negedge clk);
	enable = 1'b1;
	send_addr(1'b0, addr);
	read_burst(stored_burst(addr), 1'b0);
	end_test();
endtask

task automatic backpressure_order();
	axi_addr_t a0;
	axi_addr_t a1;
	begin_test("backpressure");
	a0 = random_addr();
	a1 = random_addr();
	// Two distinct requests so the held fields show which one is buffered
	if (a1 == a0)
		a1 = a0 ^ 32'h10;
	stall = 1'b1;
	send_addr(1'b0, a0);
	s_araddr = a1;
	s_arvalid = 1'b1;
	repeat (5) begin
		@(posedge clk);
		check(1, m_arvalid);
		check(a0, m_araddr);
		check(3, m_arlen);
		check(0, s_arready);
	end
	@(negedge clk);
	stall = 1'b0;
	send_addr(1'b0, a1);
	read_burst(stored_burst(a0), 1'b0);
	read_burst(stored_burst(a1), 1'b0);
	end_test();
endtask

task automatic clear_flush();
	axi_addr_t addr;
	begin_test("clear");
	addr = random_addr();
	stall = 1'b1;
	send_addr(1'b0, addr);
	clear = 1'b1;
	@(negedge clk);
	clear = 1'b0;
	stall = 1'b0;
	repeat (5) begin
		@(posedge clk);
		check(0, m_arvalid);
		check(0, s_rvalid);
	end
	@(negedge clk);
	check(1, idle);
	end_test();
endtask

`endif

// File: verif/axi_access_port_tb.sv
`default_nettype none

`include "axi_port_defs.svh"

module axi_access_port_tb;

	import axi_port_pkg::*;

	// About six tests of at most 300 cycles each, with margin
	localparam int MAX_CYCLES      = 2000;
	localparam int HANDSHAKE_LIMIT = 50;

	typedef logic [3:0][`AXI_DATA_W-1:0] burst_t;

	logic clk = 1'b0;
	logic rst_n;
	logic clear;
	logic enable;
	logic idle;

	axi_id_t    s_arid, s_awid, s_wid, s_rid, s_bid;
	axi_id_t    m_arid, m_awid, m_wid, m_rid, m_bid;
	axi_addr_t  s_araddr, s_awaddr, m_araddr, m_awaddr;
	axi_len_t   s_arlen, s_awlen, m_arlen, m_awlen;
	axi_size_t  s_arsize, s_awsize, m_arsize, m_awsize;
	axi_burst_t s_arburst, s_awburst, m_arburst, m_awburst;
	axi_data_t  s_wdata, m_wdata, s_rdata, m_rdata;
	axi_strb_t  s_wstrb, m_wstrb;
	axi_resp_t  s_rresp, m_rresp, s_bresp, m_bresp;
	logic s_arvalid, s_arready, s_awvalid, s_awready, s_wlast, s_wvalid, s_wready;
	logic s_rlast, s_rvalid, s_rready, s_bvalid, s_bready;
	logic m_arvalid, m_arready, m_awvalid, m_awready, m_wlast, m_wvalid, m_wready;
	logic m_rlast, m_rvalid, m_rready, m_bvalid, m_bready;

	// Memory model state
	axi_data_t  mem [0:255];
	axi_addr_t  ar_q [$];
	axi_len_t   ar_len_q [$];
	axi_id_t    ar_id_q [$];
	axi_addr_t  aw_q [$];
	axi_id_t    aw_id_q [$];
	axi_id_t    b_id = '0;
	int r_beat = 0;
	int w_beat = 0;
	int b_pending = 0;
	logic stall;

	string test_name = "reset";
	int test_errs = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;
	logic [31:0] rng_state = 32'hbab9eda8;

	always #5 clk = ~clk;

	axi_access_port #(.MEM_OP_TYPE(`MEM_OP_RW)) axi_access_port_i (.*);

	// **************************************************************************
	// Memory model on the manager side
	// **************************************************************************

	assign m_arready = ~stall;
	assign m_awready = ~stall;
	assign m_wready  = 1'b1;

	always @(posedge clk) begin
		if (rst_n) begin
			if (m_rvalid && m_rready) begin
				if (m_rlast) begin
					void'(ar_q.pop_front());
					void'(ar_len_q.pop_front());
					void'(ar_id_q.pop_front());
					r_beat = 0;
				end else begin
					r_beat++;
				end
			end
			if (m_arvalid && m_arready) begin
				ar_q.push_back(m_araddr);
				ar_len_q.push_back(m_arlen);
				ar_id_q.push_back(m_arid);
			end
			if (m_awvalid && m_awready) begin
				aw_q.push_back(m_awaddr);
				aw_id_q.push_back(m_awid);
			end
			if (m_wvalid && m_wready) begin
				if (aw_q.size() == 0) begin
					$display("%s: write data arrived with no write address", test_name);
					test_errs++;
				end else begin
					mem[word_index(aw_q[0], w_beat)] = m_wdata;
					w_beat++;
					if (m_wlast) begin
						void'(aw_q.pop_front());
						b_id = aw_id_q.pop_front();
						w_beat = 0;
						b_pending++;
					end
				end
			end
			if (m_bvalid && m_bready)
				b_pending--;
		end
	end

	// Responses change on the falling edge
	always @(negedge clk) begin
		m_rvalid = (ar_q.size() != 0);
		m_rid = '0;
		m_rdata = '0;
		m_rlast = 1'b0;
		if (m_rvalid) begin
			m_rid = ar_id_q[0];
			m_rdata = mem[word_index(ar_q[0], r_beat)];
			m_rlast = (r_beat == int'(ar_len_q[0]));
		end
		m_bvalid = (b_pending != 0);
		m_bid = b_id;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Run timed out after %0d cycles", cycle_count);
			$display("TEST FAIL");
			$finish;
		end
	end

	// **************************************************************************
	// Helpers
	// **************************************************************************

	function automatic int word_index(input axi_addr_t addr, input int beat);
		return (addr[9:2] + beat) % 256;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Aligned to 16 bytes so a four-beat burst stays inside the model
	function automatic axi_addr_t random_addr();
		logic [31:0] r;
		r = next_random();
		return {22'd0, r[9:4], 4'h0};
	endfunction

	function automatic burst_t stored_burst(input axi_addr_t addr);
		burst_t words;
		for (int i = 0; i < 4; i++)
			words[i] = mem[word_index(addr, i)];
		return words;
	endfunction

	task automatic check(input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error: %s expected %h actual %h", test_name, expected, actual);
			test_errs++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			$display("%s: passed", test_name);
			pass_count++;
		end else begin
			$display("%s: failed with %0d errors", test_name, test_errs);
			fail_count++;
		end
	endtask

	`include "axi_access_port_tests.svh"

	initial begin
		rst_n = 1'b0;
		clear = 1'b0;
		enable = 1'b1;
		stall = 1'b0;
		// Non-zero IDs so the echoed ID can be told apart from a stuck bus
		s_arid = 4'h3;
		s_awid = 4'h9;
		s_wid = 4'h9;
		{s_araddr, s_awaddr} = '0;
		// Four beats of four bytes, INCR
		{s_arlen, s_awlen} = {8'd3, 8'd3};
		{s_arsize, s_awsize} = {3'd2, 3'd2};
		{s_arburst, s_awburst} = {2'd1, 2'd1};
		{s_arvalid, s_awvalid, s_wvalid, s_wlast} = '0;
		s_wdata = '0;
		s_wstrb = '1;
		s_rready = 1'b1;
		s_bready = 1'b1;
		{m_rid, m_bid, m_rresp, m_bresp} = '0;
		{m_rdata, m_rlast, m_rvalid, m_bvalid} = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hc0de0000 ^ (i * 32'h00010203);

		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		idle_tracking();
		write_then_read();
		disable_gating();
		backpressure_order();
		clear_flush();

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
+incdir+verif
verilog/axi_port_pkg.sv
verilog/axi_addr_stage.sv
verilog/axi_outstanding_tracker.sv
verilog/axi_access_port.sv
verif/axi_access_port_tb.sv
